/* hdl/valu.sv */
// element-wise integer alu
`timescale 1ns/10ps
`default_nettype none

module valu (
    input  vfu_pkg::instr_type_t instr_type_i,
    input  vfu_pkg::sew_t        sew_i,
    input  vfu_pkg::bus64_t      data_vs1_i,
    input  vfu_pkg::bus64_t      data_vs2_i,
    output vfu_pkg::bus64_t      data_vd_o
);
    import vfu_pkg::*;

    bus64_t sum;
    bus64_t diff;   // vs2 - vs1

    // carries stop at each element boundary
    always_comb begin
        sum  = '0;
        diff = '0;
        case (sew_i)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    sum[i*8 +: 8]  = data_vs2_i[i*8 +: 8] + data_vs1_i[i*8 +: 8];
                    diff[i*8 +: 8] = data_vs2_i[i*8 +: 8] - data_vs1_i[i*8 +: 8];
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    sum[i*16 +: 16]  = data_vs2_i[i*16 +: 16] + data_vs1_i[i*16 +: 16];
                    diff[i*16 +: 16] = data_vs2_i[i*16 +: 16] - data_vs1_i[i*16 +: 16];
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    sum[i*32 +: 32]  = data_vs2_i[i*32 +: 32] + data_vs1_i[i*32 +: 32];
                    diff[i*32 +: 32] = data_vs2_i[i*32 +: 32] - data_vs1_i[i*32 +: 32];
                end
            end
            default: begin
                sum  = data_vs2_i + data_vs1_i;
                diff = data_vs2_i - data_vs1_i;
            end
        endcase
    end

    always_comb begin
        case (instr_type_i)
            VADD:    data_vd_o = sum;
            VSUB:    data_vd_o = diff;
            VAND:    data_vd_o = data_vs2_i & data_vs1_i;
            VOR:     data_vd_o = data_vs2_i | data_vs1_i;
            VXOR:    data_vd_o = data_vs2_i ^ data_vs1_i;
            default: data_vd_o = '0;  // shifts and unused codes
        endcase
    end

endmodule

`default_nettype wire

/* hdl/vexec_if.sv */
// request and result path to the execution stage
`timescale 1ns/10ps
`default_nettype none

interface vexec_if;
    import vfu_pkg::*;

    // request side, one cycle per operation
    logic        req_valid;
    instr_type_t op;
    sew_t        sew;
    bus64_t      vs1;       // shift amounts for shift ops
    bus64_t      vs2;

    // result side
    logic        res_valid;
    bus64_t      res_data;

    modport regs (
        output req_valid, op, sew, vs1, vs2,
        input  res_valid, res_data
    );

    modport exec (
        input  req_valid, op, sew, vs1, vs2,
        output res_valid, res_data
    );

endinterface

`default_nettype wire

/* hdl/vfu_exec.sv */
// execution stage, shifter and alu behind one result register
`timescale 1ns/10ps
`default_nettype none

module vfu_exec (
    input  logic  clk_i,
    input  logic  arst_n_i,
    vexec_if.exec exec_bus
);
    import vfu_pkg::*;

    bus64_t shift_res;
    bus64_t alu_res;
    bus64_t sel_res;
    bus64_t res_data_q;
    logic   res_valid_q;

    vshift vshift_inst (
        .instr_type_i (exec_bus.op),
        .sew_i        (exec_bus.sew),
        .data_vs1_i   (exec_bus.vs1),
        .data_vs2_i   (exec_bus.vs2),
        .data_vd_o    (shift_res)
    );

    valu valu_inst (
        .instr_type_i (exec_bus.op),
        .sew_i        (exec_bus.sew),
        .data_vs1_i   (exec_bus.vs1),
        .data_vs2_i   (exec_bus.vs2),
        .data_vd_o    (alu_res)
    );

    always_comb begin
        case (exec_bus.op)
            VSLL, VSRL, VSRA, VNSRL, VNSRA: sel_res = shift_res;
            VADD, VSUB, VAND, VOR, VXOR:    sel_res = alu_res;
            default:                        sel_res = '0;
        endcase
    end

    // one request per cycle, result lands on the next edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_q <= 1'b0;
            res_data_q  <= '0;
        end else begin
            res_valid_q <= exec_bus.req_valid;
            if (exec_bus.req_valid) begin
                res_data_q <= sel_res;
            end
        end
    end

    assign exec_bus.res_valid = res_valid_q;
    assign exec_bus.res_data  = res_data_q;

endmodule

`default_nettype wire

/* hdl/vfu_pkg.sv */
// vector unit shared types
`default_nettype none

package vfu_pkg;

    // operation codes, 10 to 15 are unused and give zero
    typedef enum logic [3:0] {
        VADD  = 4'd0,
        VSUB  = 4'd1,
        VAND  = 4'd2,
        VOR   = 4'd3,
        VXOR  = 4'd4,
        VSLL  = 4'd5,
        VSRL  = 4'd6,
        VSRA  = 4'd7,
        VNSRL = 4'd8,   // narrowing logical right
        VNSRA = 4'd9    // narrowing arithmetic right
    } instr_type_t;

    // element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // one 64-bit register slice
    typedef logic [63:0] bus64_t;

endpackage

`default_nettype wire

/* hdl/vfu_top.sv */
// vector functional unit top level
`timescale 1ns/10ps
`default_nettype none
`include "vfu_config.svh"

module vfu_top (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [`VFU_WB_ADDR_W-1:0]   wb_adr_i,
    input  vfu_pkg::bus64_t             wb_dat_i,
    input  logic [7:0]                  wb_sel_i,
    output vfu_pkg::bus64_t             wb_dat_o,
    output logic                        wb_ack_o
);

    vexec_if exec_bus ();

    // host side registers
    vfu_wb_regs vfu_wb_regs_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .exec_bus (exec_bus.regs)
    );

    vfu_exec vfu_exec_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .exec_bus (exec_bus.exec)   // 2-cycle fixed latency from ctrl ack
    );

endmodule

`default_nettype wire

/* hdl/vfu_wb_regs.sv */
// wishbone register block of the vector unit
`timescale 1ns/10ps
`default_nettype none
`include "vfu_config.svh"

module vfu_wb_regs (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [`VFU_WB_ADDR_W-1:0]   wb_adr_i,
    input  vfu_pkg::bus64_t             wb_dat_i,
    input  logic [7:0]                  wb_sel_i,   // full-word writes only, not decoded
    output vfu_pkg::bus64_t             wb_dat_o,
    output logic                        wb_ack_o,
    vexec_if.regs                       exec_bus
);
    import vfu_pkg::*;

    logic       ack_q;
    logic       access;
    logic       wr_en;
    logic       ctrl_wr_q;      // ctrl write seen on the ack edge
    logic       req_valid_q;
    logic       done_q;
    logic [7:0] count_q;
    logic [5:0] ctrl_q;
    bus64_t     vs1_q;
    bus64_t     vs2_q;
    bus64_t     result_q;
    bus64_t     rd_data;
    bus64_t     rd_data_q;

    // a live cycle is acked once, one clock later
    assign access = wb_cyc_i && wb_stb_i && !ack_q;
    assign wr_en  = access && wb_we_i;

    always_comb begin
        rd_data = '0;   // unused offsets read zero
        case (wb_adr_i)
            `VFU_REG_VS1:    rd_data = vs1_q;
            `VFU_REG_VS2:    rd_data = vs2_q;
            `VFU_REG_CTRL:   rd_data = {58'd0, ctrl_q};
            `VFU_REG_RESULT: rd_data = result_q;
            `VFU_REG_STATUS: rd_data = {48'd0, count_q, 7'd0, done_q};
            default:         rd_data = '0;
        endcase
    end

    // bus handshake and register writes
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q     <= 1'b0;
            rd_data_q <= '0;
            ctrl_wr_q <= 1'b0;
            vs1_q     <= '0;
            vs2_q     <= '0;
            ctrl_q    <= '0;
        end else begin
            ack_q     <= access;
            ctrl_wr_q <= wr_en && (wb_adr_i == `VFU_REG_CTRL);
            if (access) begin
                rd_data_q <= rd_data;
            end
            if (wr_en) begin
                case (wb_adr_i)
                    `VFU_REG_VS1:  vs1_q  <= wb_dat_i;
                    `VFU_REG_VS2:  vs2_q  <= wb_dat_i;
                    `VFU_REG_CTRL: ctrl_q <= wb_dat_i[5:0];
                    default: ;  // result, status and holes are read only
                endcase
            end
        end
    end

    // request issue and result capture
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_valid_q <= 1'b0;
            done_q      <= 1'b0;
            count_q     <= '0;
            result_q    <= '0;
        end else begin
            req_valid_q <= ctrl_wr_q;   // the cycle after ack
            if (exec_bus.res_valid) begin
                result_q <= exec_bus.res_data;
                count_q  <= count_q + 8'd1;
            end
            // a fresh start wins over an older result landing
            if (wr_en && (wb_adr_i == `VFU_REG_CTRL)) begin
                done_q <= 1'b0;
            end else if (exec_bus.res_valid) begin
                done_q <= 1'b1;
            end
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = rd_data_q;

    assign exec_bus.req_valid = req_valid_q;
    assign exec_bus.op        = instr_type_t'(ctrl_q[3:0]);
    assign exec_bus.sew       = sew_t'(ctrl_q[5:4]);
    assign exec_bus.vs1       = vs1_q;
    assign exec_bus.vs2       = vs2_q;

endmodule

`default_nettype wire

/* hdl/vshift.sv */
// vector shifter built on right shifts only
`timescale 1ns/10ps
`default_nettype none

module vshift (
    input  vfu_pkg::instr_type_t instr_type_i,
    input  vfu_pkg::sew_t        sew_i,
    input  vfu_pkg::bus64_t      data_vs1_i,    // shift amounts
    input  vfu_pkg::bus64_t      data_vs2_i,    // elements to shift
    output vfu_pkg::bus64_t      data_vd_o
);
    import vfu_pkg::*;

    bus64_t      vs2_rev;
    bus64_t      vs1_swap;
    bus64_t      data_a;
    bus64_t      data_b;
    bus64_t      data_vd;
    bus64_t      data_vd_rev;
    logic [63:0] sh;
    logic        is_signed;
    logic        is_left;
    logic        is_narrow;

    // value already extended to 65 bits, so the top fill follows bit 64
    function automatic logic [63:0] shr65(input logic [64:0] val, input logic [5:0] amt);
        logic [64:0] res;
        res = $signed(val) >>> amt;
        return res[63:0];
    endfunction

    always_comb begin
        is_signed = (instr_type_i == VSRA) || (instr_type_i == VNSRA);
        is_left   = (instr_type_i == VSLL);
        is_narrow = (instr_type_i == VNSRL) || (instr_type_i == VNSRA);

        // bit reversal also reverses element order, so the amounts get swapped to match
        for (int i = 0; i < 64; i++) begin
            vs2_rev[i] = data_vs2_i[63-i];
        end
        vs1_swap = data_vs1_i;
        case (sew_i)
            SEW_8:  for (int i = 0; i < 8; i++) vs1_swap[i*8 +: 8] = data_vs1_i[63-i*8 -: 8];
            SEW_16: for (int i = 0; i < 4; i++) vs1_swap[i*16 +: 16] = data_vs1_i[63-i*16 -: 16];
            SEW_32: for (int i = 0; i < 2; i++) vs1_swap[i*32 +: 32] = data_vs1_i[63-i*32 -: 32];
            default: vs1_swap = data_vs1_i;
        endcase

        data_a = is_left ? vs2_rev  : data_vs2_i;
        data_b = is_left ? vs1_swap : data_vs1_i;

        sh      = '0;
        data_vd = '0;
        if (is_narrow) begin
            // 2*sew sources, amount mod 2*sew, packed into the low half
            case (sew_i)
                SEW_8: begin
                    for (int i = 0; i < 4; i++) begin
                        sh = shr65({{49{is_signed & data_a[i*16+15]}}, data_a[i*16 +: 16]},
                                   {2'b00, data_b[i*8 +: 4]});
                        data_vd[i*8 +: 8] = sh[7:0];
                    end
                end
                SEW_16: begin
                    for (int i = 0; i < 2; i++) begin
                        sh = shr65({{33{is_signed & data_a[i*32+31]}}, data_a[i*32 +: 32]},
                                   {1'b0, data_b[i*16 +: 5]});
                        data_vd[i*16 +: 16] = sh[15:0];
                    end
                end
                SEW_32: begin
                    sh = shr65({is_signed & data_a[63], data_a}, data_b[5:0]);
                    data_vd[31:0] = sh[31:0];
                end
                default: data_vd = shr65({is_signed & data_a[63], data_a}, data_b[5:0]);
            endcase
        end else begin
            case (sew_i)
                SEW_8: begin
                    for (int i = 0; i < 8; i++) begin
                        sh = shr65({{57{is_signed & data_a[i*8+7]}}, data_a[i*8 +: 8]},
                                   {3'b000, data_b[i*8 +: 3]});
                        data_vd[i*8 +: 8] = sh[7:0];
                    end
                end
                SEW_16: begin
                    for (int i = 0; i < 4; i++) begin
                        sh = shr65({{49{is_signed & data_a[i*16+15]}}, data_a[i*16 +: 16]},
                                   {2'b00, data_b[i*16 +: 4]});
                        data_vd[i*16 +: 16] = sh[15:0];
                    end
                end
                SEW_32: begin
                    for (int i = 0; i < 2; i++) begin
                        sh = shr65({{33{is_signed & data_a[i*32+31]}}, data_a[i*32 +: 32]},
                                   {1'b0, data_b[i*32 +: 5]});
                        data_vd[i*32 +: 32] = sh[31:0];
                    end
                end
                default: data_vd = shr65({is_signed & data_a[63], data_a}, data_b[5:0]);
            endcase
        end

        for (int i = 0; i < 64; i++) begin
            data_vd_rev[i] = data_vd[63-i];   // undo the reversal for left shifts
        end
        data_vd_o = is_left ? data_vd_rev : data_vd;
    end

endmodule

`default_nettype wire

/* include/vfu_config.svh */
// vector unit bus and register map
`ifndef VFU_CONFIG_SVH
`define VFU_CONFIG_SVH

// wishbone word address width
`define VFU_WB_ADDR_W 3

// register offsets by word address
`define VFU_REG_VS1    0
`define VFU_REG_VS2    1
`define VFU_REG_CTRL   2   // [3:0] operation, [5:4] element width, a write starts the op
`define VFU_REG_RESULT 3
`define VFU_REG_STATUS 4   // [0] done, [15:8] completed op count (wraps at 256)

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# build the vector unit testbench with verilator, run it and check the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=vfu_tb

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
        -f verilog.f --top-module "$TOP" -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* test/vfu_tb.sv */
// vector unit testbench
`timescale 1ns/10ps
`default_nettype none
`include "vfu_config.svh"

module vfu_tb;
    import vfu_pkg::*;

    localparam int MAX_CYCLES = 20000;  // about 300 ops at 12 cycles each plus margin

    logic                       clk_i;
    logic                       arst_n_i;
    logic                       wb_cyc_i;
    logic                       wb_stb_i;
    logic                       wb_we_i;
    logic [`VFU_WB_ADDR_W-1:0]  wb_adr_i;
    bus64_t                     wb_dat_i;
    logic [7:0]                 wb_sel_i;
    bus64_t                     wb_dat_o;
    logic                       wb_ack_o;

    integer     seed;
    logic [7:0] op_count;           // ctrl writes so far modulo 256 like the status count
    logic       ack_prev    = 1'b0; // ack at the previous falling edge
    int         cycle_count = 0;

    vfu_top vfu_top_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    // ack must drop after one cycle
    always @(negedge clk_i) begin
        ack_prev <= wb_ack_o;
        assert (!(ack_prev && wb_ack_o)) else begin
            $display("wishbone ack stayed high for more than one cycle");
            $display("Errors found");
            $fatal(1, "bus protocol error");
        end
    end

    task automatic check_word(input string name, input bus64_t got, input bus64_t exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%016h, expected 0x%016h", name, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // one classic cycle that starts and returns on a falling edge
    task automatic wb_access(input logic we, input logic [`VFU_WB_ADDR_W-1:0] adr,
                             input bus64_t wdata, output bus64_t rdata);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        @(negedge clk_i);
        while (!wb_ack_o) @(negedge clk_i);
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    function automatic bus64_t width_mask(input bus64_t w);
        return (w >= 64'd64) ? '1 : ((64'd1 << w) - 64'd1);
    endfunction

    function automatic bus64_t splat(input sew_t sew, input bus64_t val);
        bus64_t w;
        bus64_t i;
        bus64_t res;
        w   = 64'd8 << sew;
        res = '0;
        for (i = 0; i < 64'd64 / w; i++) res |= (val & width_mask(w)) << (i * w);
        return res;
    endfunction

    function automatic bus64_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // expected vd computed element by element
    function automatic bus64_t ref_result(input logic [3:0] op, input sew_t sew,
                                          input bus64_t vs1, input bus64_t vs2);
        bus64_t w;
        bus64_t sw;         // source element width, doubled when narrowing
        bus64_t i;
        bus64_t a;
        bus64_t b;
        bus64_t r;
        bus64_t res;
        logic   narrow;
        w      = 64'd8 << sew;
        narrow = (op == VNSRL || op == VNSRA) && (sew != SEW_64);
        sw     = narrow ? 64'd2 * w : w;
        res    = '0;
        if (op >= 4'd10) return '0;
        for (i = 0; i < (narrow ? 64'd32 : 64'd64) / w; i++) begin
            a = (vs2 >> (i * sw)) & width_mask(sw);
            b = (vs1 >> (i * w)) & width_mask(w);
            case (op)
                VADD:        r = a + b;
                VSUB:        r = a - b;
                VAND:        r = a & b;
                VOR:         r = a | b;
                VXOR:        r = a ^ b;
                VSLL:        r = a << (b & (sw - 64'd1));
                VSRL, VNSRL: r = a >> (b & (sw - 64'd1));
                default: begin
                    if (((a >> (sw - 64'd1)) & 64'd1) != 64'd0) a = a | ~width_mask(sw);
                    r = $signed(a) >>> (b & (sw - 64'd1));
                end
            endcase
            res |= (r & width_mask(w)) << (i * w);
        end
        return res;
    endfunction

    task automatic run_op(input logic [3:0] op, input sew_t sew, input bus64_t vs1,
                          input bus64_t vs2);
        bus64_t rdata;
        wb_access(1'b1, `VFU_REG_VS1, vs1, rdata);
        wb_access(1'b1, `VFU_REG_VS2, vs2, rdata);
        wb_access(1'b1, `VFU_REG_CTRL, {58'd0, sew, op}, rdata);
        op_count = op_count + 8'd1;
        wb_access(1'b0, `VFU_REG_STATUS, '0, rdata);      // still inside the latency
        check_word("STATUS", rdata, {48'd0, op_count - 8'd1, 7'd0, 1'b0});
        wb_access(1'b0, `VFU_REG_STATUS, '0, rdata);
        check_word("STATUS", rdata, {48'd0, op_count, 7'd0, 1'b1});
        wb_access(1'b0, `VFU_REG_RESULT, '0, rdata);
        check_word($sformatf("RESULT op %0d sew %0d", op, sew), rdata,
                   ref_result(op, sew, vs1, vs2));
    endtask

    initial begin
        bus64_t rdata;
        bus64_t neg;
        bus64_t ew;
        sew_t   sew;
        seed     = 38938;
        op_count = '0;
        arst_n_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = 8'hff;
        repeat (10) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);

        wb_access(1'b0, `VFU_REG_RESULT, '0, rdata);
        check_word("RESULT", rdata, '0);
        wb_access(1'b0, `VFU_REG_STATUS, '0, rdata);
        check_word("STATUS", rdata, '0);
        wb_access(1'b1, `VFU_REG_RESULT, 64'hdead_beef_0123_4567, rdata);
        wb_access(1'b1, `VFU_REG_STATUS, '1, rdata);
        wb_access(1'b0, `VFU_REG_RESULT, '0, rdata);
        check_word("RESULT", rdata, '0);
        wb_access(1'b0, `VFU_REG_STATUS, '0, rdata);
        check_word("STATUS", rdata, '0);

        for (int k = 0; k < 10; k++) begin
            for (int s = 0; s < 4; s++) begin
                sew = sew_t'(2'(s));
                ew  = 64'd8 << sew;
                neg = rand_word() | splat(sew, 64'd1 << (ew - 64'd1));  // negative elements
                if (k < 5) begin
                    run_op(4'(k), sew, splat(sew, 64'd1), '1);  // all ones plus one
                end else if (k < 8) begin
                    run_op(4'(k), sew, '0, neg);
                    run_op(4'(k), sew, splat(sew, ew - 64'd1), neg);
                end else begin
                    run_op(4'(k), sew, rand_word(), rand_word() | 64'h8000_8000_8000_8000);
                end
                repeat (6) run_op(4'(k), sew, rand_word(), rand_word());
            end
        end

        for (int k = 10; k < 16; k++) run_op(4'(k), SEW_32, rand_word(), rand_word());

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hdl/vfu_pkg.sv
hdl/vexec_if.sv
hdl/valu.sv
hdl/vshift.sv
hdl/vfu_wb_regs.sv
hdl/vfu_exec.sv
hdl/vfu_top.sv
test/vfu_tb.sv
